// File: design/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// width of a register file address, x0..x31
`define REG_ADDR_W 5

// request credits the peripheral bus grants after reset
// the port never holds more than this
`define BUS_CREDITS 2

`endif

// File: design/pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

  // where the writeback value of an instruction comes from
  typedef enum logic [1:0] {
    ALU           = 2'd0,
    DMEM_RD_DATA  = 2'd1,
    CSR_READ_DATA = 2'd2,
    PC_PLUS4      = 2'd3
  } result_src_e;

  // operand source select for the EX stage operand muxes
  typedef enum logic [2:0] {
    NO_FORWARD      = 3'd0,
    MEM1_ALU_RESULT = 3'd1,
    MEM2_MEM_RDATA  = 3'd2,
    MEM2_ALU_RESULT = 3'd3,
    WB_RESULT       = 3'd4
  } forward_sel_e;

  // peripheral request port states
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WAIT_CREDIT = 2'd1,
    WAIT_RSP    = 2'd2
  } port_state_e;

  // control view of one instruction in a pipeline stage
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    result_src_e            result_src;
    logic                   branch_taken;
    // load/store to the peripheral bus
    logic                   periph;
    logic                   trap_valid;
  } stage_ctrl_t;

  // stall and flush bits for the pipeline registers
  typedef struct packed {
    logic if_stall;
    logic id_stall;
    logic ex_stall;
    logic mem1_stall;
    logic id_flush;
    logic ex_flush;
    logic mem1_flush;
    logic mem2_flush;
    logic wb_flush;
  } hazard_ctrl_t;

endpackage

// File: design/hazard_unit.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module hazard_unit (
  input  pipe_pkg::stage_ctrl_t  id_ctrl,
  input  pipe_pkg::stage_ctrl_t  ex_ctrl,
  input  pipe_pkg::stage_ctrl_t  mem1_ctrl,
  input  pipe_pkg::stage_ctrl_t  mem2_ctrl,
  input  pipe_pkg::stage_ctrl_t  wb_ctrl,
  input  logic                   periph_stall,
  output pipe_pkg::hazard_ctrl_t hazard,
  output pipe_pkg::forward_sel_e ex_fwd_a,
  output pipe_pkg::forward_sel_e ex_fwd_b,
  output logic                   id_fwd_a,
  output logic                   id_fwd_b
);

  // a valid producer writes the register that src reads, x0 excluded
  function automatic logic writes_reg(
    input logic [`REG_ADDR_W-1:0] src,
    input pipe_pkg::stage_ctrl_t  prod
  );
    return prod.valid && (src != '0) && (prod.rd_addr == src);
  endfunction

  // valid ID instruction reads a register written by prod
  function automatic logic id_reads(
    input pipe_pkg::stage_ctrl_t id,
    input pipe_pkg::stage_ctrl_t prod
  );
    return id.valid && (writes_reg(id.rs1_addr, prod) || writes_reg(id.rs2_addr, prod));
  endfunction

  // youngest producer wins, MEM2 load data before MEM2 alu data
  function automatic pipe_pkg::forward_sel_e ex_fwd_sel(
    input logic [`REG_ADDR_W-1:0] src,
    input pipe_pkg::stage_ctrl_t  mem1,
    input pipe_pkg::stage_ctrl_t  mem2,
    input pipe_pkg::stage_ctrl_t  wb
  );
    pipe_pkg::forward_sel_e sel;
    if (writes_reg(src, mem1)) begin
      sel = pipe_pkg::MEM1_ALU_RESULT;
    end else if (writes_reg(src, mem2) && (mem2.result_src == pipe_pkg::DMEM_RD_DATA)) begin
      sel = pipe_pkg::MEM2_MEM_RDATA;
    end else if (writes_reg(src, mem2)) begin
      sel = pipe_pkg::MEM2_ALU_RESULT;
    end else if (writes_reg(src, wb)) begin
      sel = pipe_pkg::WB_RESULT;
    end else begin
      sel = pipe_pkg::NO_FORWARD;
    end
    return sel;
  endfunction

  logic redirect;
  logic ex_trap;
  logic mem1_trap;
  logic mem2_trap;
  logic wb_trap;
  logic load_use_stall;
  logic csr_use_stall;
  logic use_stall;

  // taken branch or jump resolved in EX
  assign redirect  = ex_ctrl.valid & ex_ctrl.branch_taken;

  assign ex_trap   = ex_ctrl.valid & ex_ctrl.trap_valid;
  assign mem1_trap = mem1_ctrl.valid & mem1_ctrl.trap_valid;
  assign mem2_trap = mem2_ctrl.valid & mem2_ctrl.trap_valid;
  assign wb_trap   = wb_ctrl.valid & wb_ctrl.trap_valid;

  // load data is not ready before MEM2, so one bubble is needed
  assign load_use_stall = (ex_ctrl.result_src == pipe_pkg::DMEM_RD_DATA) &&
                          id_reads(id_ctrl, ex_ctrl);

  // csr read data only shows up at writeback
  assign csr_use_stall =
    ((ex_ctrl.result_src == pipe_pkg::CSR_READ_DATA) && id_reads(id_ctrl, ex_ctrl)) ||
    ((mem1_ctrl.result_src == pipe_pkg::CSR_READ_DATA) && id_reads(id_ctrl, mem1_ctrl)) ||
    ((mem2_ctrl.result_src == pipe_pkg::CSR_READ_DATA) && id_reads(id_ctrl, mem2_ctrl));

  // the ID instruction is thrown away on a redirect, no point stalling it
  assign use_stall = (load_use_stall | csr_use_stall) & ~redirect;

  assign ex_fwd_a = ex_fwd_sel(ex_ctrl.rs1_addr, mem1_ctrl, mem2_ctrl, wb_ctrl);
  assign ex_fwd_b = ex_fwd_sel(ex_ctrl.rs2_addr, mem1_ctrl, mem2_ctrl, wb_ctrl);

  // register file write and read land in the same cycle
  assign id_fwd_a = writes_reg(id_ctrl.rs1_addr, wb_ctrl);
  assign id_fwd_b = writes_reg(id_ctrl.rs2_addr, wb_ctrl);

  always_comb begin
    hazard.if_stall   = use_stall | periph_stall;
    hazard.id_stall   = use_stall | periph_stall;
    hazard.ex_stall   = periph_stall;
    hazard.mem1_stall = periph_stall;

    // a trap kills everything younger than itself
    hazard.id_flush   = redirect | ex_trap | mem1_trap | mem2_trap | wb_trap;
    hazard.ex_flush   = (redirect & ~periph_stall) | mem1_trap | mem2_trap | wb_trap;
    hazard.mem1_flush = mem2_trap | wb_trap;
    hazard.mem2_flush = wb_trap;
    hazard.wb_flush   = wb_trap;
  end

endmodule

// File: design/stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker (
  input  logic                   clk,
  input  logic                   arst_n,
  input  pipe_pkg::stage_ctrl_t  id_ctrl,
  input  pipe_pkg::hazard_ctrl_t hazard,
  output pipe_pkg::stage_ctrl_t  ex_ctrl,
  output pipe_pkg::stage_ctrl_t  mem1_ctrl,
  output pipe_pkg::stage_ctrl_t  mem2_ctrl,
  output pipe_pkg::stage_ctrl_t  wb_ctrl
);

  localparam pipe_pkg::stage_ctrl_t BUBBLE = '0;

  // next content of one stage register
  // flush beats hold, hold beats a bubble from a stalled predecessor
  function automatic pipe_pkg::stage_ctrl_t next_stage(
    input pipe_pkg::stage_ctrl_t cur,
    input pipe_pkg::stage_ctrl_t prev,
    input logic                  flush,
    input logic                  stall,
    input logic                  prev_stall
  );
    pipe_pkg::stage_ctrl_t nxt;
    if (flush) begin
      nxt = BUBBLE;
    end else if (stall) begin
      nxt = cur;
    end else if (prev_stall) begin
      nxt = BUBBLE;
    end else begin
      nxt = prev;
    end
    return nxt;
  endfunction

  pipe_pkg::stage_ctrl_t id_in;
  pipe_pkg::stage_ctrl_t ex_nxt;
  pipe_pkg::stage_ctrl_t mem1_nxt;
  pipe_pkg::stage_ctrl_t mem2_nxt;
  pipe_pkg::stage_ctrl_t wb_nxt;

  // an empty decode slot enters EX as a clean bubble
  assign id_in = id_ctrl.valid ? id_ctrl : BUBBLE;

  assign ex_nxt = next_stage(ex_ctrl, id_in, hazard.ex_flush, hazard.ex_stall,
                             hazard.id_stall);

  assign mem1_nxt = next_stage(mem1_ctrl, ex_ctrl, hazard.mem1_flush, hazard.mem1_stall,
                               hazard.ex_stall);

  // MEM2 and WB never hold, they drain behind a stalled MEM1
  assign mem2_nxt = next_stage(mem2_ctrl, mem1_ctrl, hazard.mem2_flush, 1'b0,
                               hazard.mem1_stall);

  assign wb_nxt = next_stage(wb_ctrl, mem2_ctrl, hazard.wb_flush, 1'b0, 1'b0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_ctrl   <= BUBBLE;
      mem1_ctrl <= BUBBLE;
      mem2_ctrl <= BUBBLE;
      wb_ctrl   <= BUBBLE;
    end else begin
      ex_ctrl   <= ex_nxt;
      mem1_ctrl <= mem1_nxt;
      mem2_ctrl <= mem2_nxt;
      wb_ctrl   <= wb_nxt;
    end
  end

endmodule

// File: design/periph_credit_port.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module periph_credit_port (
  input  logic                   clk,
  input  logic                   arst_n,
  input  pipe_pkg::stage_ctrl_t  mem1_ctrl,
  input  logic                   periph_credit_return,
  input  logic                   periph_rsp_valid,
  output logic                   periph_req_valid,
  output logic [`REG_ADDR_W-1:0] periph_req_tag,
  output logic                   periph_stall
);

  localparam int               CNT_W       = $clog2(`BUS_CREDITS + 1);
  localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(`BUS_CREDITS);

  pipe_pkg::port_state_e state;
  pipe_pkg::port_state_e state_nxt;
  logic [CNT_W-1:0]      credit_cnt;
  logic                  mem1_periph;
  logic                  issue;
  logic                  rsp_done;

  assign mem1_periph = mem1_ctrl.valid & mem1_ctrl.periph;

  // IDLE counts as passing through WAIT_CREDIT, so a free credit
  // lets the request go out in the cycle the access reaches MEM1
  assign issue    = mem1_periph && (state != pipe_pkg::WAIT_RSP) && (credit_cnt != '0);
  assign rsp_done = (state == pipe_pkg::WAIT_RSP) && periph_rsp_valid;

  assign periph_req_valid = issue;
  assign periph_req_tag   = mem1_ctrl.rd_addr;
  // drops in the response cycle so the access leaves MEM1 on that edge
  assign periph_stall     = mem1_periph & ~rsp_done;

  always_comb begin
    state_nxt = state;
    case (state)
      pipe_pkg::IDLE, pipe_pkg::WAIT_CREDIT: begin
        if (issue) begin
          state_nxt = pipe_pkg::WAIT_RSP;
        end else if (mem1_periph) begin
          state_nxt = pipe_pkg::WAIT_CREDIT;
        end else begin
          // access flushed before it got a credit
          state_nxt = pipe_pkg::IDLE;
        end
      end
      pipe_pkg::WAIT_RSP: begin
        if (periph_rsp_valid) begin
          state_nxt = pipe_pkg::IDLE;
        end
      end
      default: state_nxt = pipe_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= pipe_pkg::IDLE;
      credit_cnt <= MAX_CREDITS;
    end else begin
      state <= state_nxt;
      // return and issue in one cycle cancel out
      case ({periph_credit_return, issue})
        2'b10: begin
          if (credit_cnt != MAX_CREDITS) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        2'b01: credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: design/pipe_ctrl_top.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_ctrl_top (
  input  logic                   clk,
  input  logic                   arst_n,
  // decoded instruction in the ID slot
  input  pipe_pkg::stage_ctrl_t  id_ctrl,
  input  logic                   periph_credit_return,
  input  logic                   periph_rsp_valid,
  output pipe_pkg::hazard_ctrl_t hazard,
  output pipe_pkg::forward_sel_e ex_fwd_a,
  output pipe_pkg::forward_sel_e ex_fwd_b,
  output logic                   id_fwd_a,
  output logic                   id_fwd_b,
  output pipe_pkg::stage_ctrl_t  wb_ctrl,
  output logic                   periph_req_valid,
  output logic [`REG_ADDR_W-1:0] periph_req_tag
);

  pipe_pkg::stage_ctrl_t ex_ctrl;
  pipe_pkg::stage_ctrl_t mem1_ctrl;
  pipe_pkg::stage_ctrl_t mem2_ctrl;
  logic                  periph_stall;

  stage_tracker u_stage_tracker (
    .clk       (clk),
    .arst_n    (arst_n),
    .id_ctrl   (id_ctrl),
    .hazard    (hazard),
    .ex_ctrl   (ex_ctrl),
    .mem1_ctrl (mem1_ctrl),
    .mem2_ctrl (mem2_ctrl),
    .wb_ctrl   (wb_ctrl)
  );

  hazard_unit u_hazard_unit (
    .id_ctrl      (id_ctrl),
    .ex_ctrl      (ex_ctrl),
    .mem1_ctrl    (mem1_ctrl),
    .mem2_ctrl    (mem2_ctrl),
    .wb_ctrl      (wb_ctrl),
    .periph_stall (periph_stall),
    .hazard       (hazard),
    .ex_fwd_a     (ex_fwd_a),
    .ex_fwd_b     (ex_fwd_b),
    .id_fwd_a     (id_fwd_a),
    .id_fwd_b     (id_fwd_b)
  );

  // MEM1 peripheral access, source of the bus stall
  periph_credit_port u_periph_credit_port (
    .clk                  (clk),
    .arst_n               (arst_n),
    .mem1_ctrl            (mem1_ctrl),
    .periph_credit_return (periph_credit_return),
    .periph_rsp_valid     (periph_rsp_valid),
    .periph_req_valid     (periph_req_valid),
    .periph_req_tag       (periph_req_tag),
    .periph_stall         (periph_stall)
  );

endmodule

// File: test/tb_pipe_ctrl.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module tb_pipe_ctrl;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_VEC    = 256;
  localparam int NUM_FIELDS = 18;
  localparam     VEC_FILE   = "test/pipe_ctrl_testdata.txt";

  // one cycle of stimulus and the outputs expected in that cycle
  typedef struct packed {
    pipe_pkg::stage_ctrl_t  id_ctrl;
    logic                   credit_return;
    logic                   rsp_valid;
    logic [8:0]             exp_hazard;
    logic [2:0]             exp_fwd_a;
    logic [2:0]             exp_fwd_b;
    logic                   exp_id_fwd_a;
    logic                   exp_id_fwd_b;
    logic                   exp_wb_valid;
    logic [`REG_ADDR_W-1:0] exp_wb_rd;
    logic                   exp_req_valid;
  } vector_t;

  logic                   clk;
  logic                   arst_n;
  pipe_pkg::stage_ctrl_t  id_ctrl;
  logic                   periph_credit_return;
  logic                   periph_rsp_valid;
  pipe_pkg::hazard_ctrl_t hazard;
  pipe_pkg::forward_sel_e ex_fwd_a;
  pipe_pkg::forward_sel_e ex_fwd_b;
  logic                   id_fwd_a;
  logic                   id_fwd_b;
  pipe_pkg::stage_ctrl_t  wb_ctrl;
  logic                   periph_req_valid;
  logic [`REG_ADDR_W-1:0] periph_req_tag;

  vector_t vecs [MAX_VEC];
  int      num_vec     = 0;
  int      checks      = 0;
  int      errors      = 0;
  int      cycle_cnt   = 0;
  int      cycle_limit = MAX_VEC + 20;

  // rd of periph accesses that left ID, oldest first
  logic [`REG_ADDR_W-1:0] tag_q [$];

  pipe_ctrl_top u_dut (
    .clk                  (clk),
    .arst_n               (arst_n),
    .id_ctrl              (id_ctrl),
    .periph_credit_return (periph_credit_return),
    .periph_rsp_valid     (periph_rsp_valid),
    .hazard               (hazard),
    .ex_fwd_a             (ex_fwd_a),
    .ex_fwd_b             (ex_fwd_b),
    .id_fwd_a             (id_fwd_a),
    .id_fwd_b             (id_fwd_b),
    .wb_ctrl              (wb_ctrl),
    .periph_req_valid     (periph_req_valid),
    .periph_req_tag       (periph_req_tag)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic finish_run();
    $display("vectors %0d, checks %0d, errors %0d", num_vec, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // run length is bounded by the vector count
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("ERROR: timeout, run did not end within %0d cycles", cycle_limit);
      errors++;
      finish_run();
    end
  end

  task automatic load_vectors();
    int          fd;
    int          cnt;
    int          line_no;
    string       line;
    logic [31:0] f [NUM_FIELDS];
    vector_t     v;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open vector file %s", VEC_FILE);
      errors++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      line_no++;
      // skip blank and comment lines
      if (cnt <= 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
      if (cnt != NUM_FIELDS) begin
        $display("ERROR: line %0d of %s is malformed, found %0d of %0d fields",
                 line_no, VEC_FILE, cnt, NUM_FIELDS);
        errors++;
        continue;
      end
      if (num_vec == MAX_VEC) begin
        $display("ERROR: %s holds more than %0d vectors", VEC_FILE, MAX_VEC);
        errors++;
        break;
      end
      v.id_ctrl.valid        = f[0][0];
      v.id_ctrl.rs1_addr     = f[1][`REG_ADDR_W-1:0];
      v.id_ctrl.rs2_addr     = f[2][`REG_ADDR_W-1:0];
      v.id_ctrl.rd_addr      = f[3][`REG_ADDR_W-1:0];
      v.id_ctrl.result_src   = pipe_pkg::result_src_e'(f[4][1:0]);
      v.id_ctrl.branch_taken = f[5][0];
      v.id_ctrl.periph       = f[6][0];
      v.id_ctrl.trap_valid   = f[7][0];
      v.credit_return        = f[8][0];
      v.rsp_valid            = f[9][0];
      v.exp_hazard           = f[10][8:0];
      v.exp_fwd_a            = f[11][2:0];
      v.exp_fwd_b            = f[12][2:0];
      v.exp_id_fwd_a         = f[13][0];
      v.exp_id_fwd_b         = f[14][0];
      v.exp_wb_valid         = f[15][0];
      v.exp_wb_rd            = f[16][`REG_ADDR_W-1:0];
      v.exp_req_valid        = f[17][0];
      vecs[num_vec] = v;
      num_vec++;
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input int idx);
    id_ctrl              <= vecs[idx].id_ctrl;
    periph_credit_return <= vecs[idx].credit_return;
    periph_rsp_valid     <= vecs[idx].rsp_valid;
  endtask

  task automatic compare_field(input string name, input int idx,
                               input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s at vector %0d: got 0x%0h, expected 0x%0h", name, idx, got, exp);
      errors++;
    end
  endtask

  // an access leaves ID when it is neither held nor dropped there
  task automatic track_periph_accept(input int idx);
    pipe_pkg::hazard_ctrl_t exp_h;
    exp_h = vecs[idx].exp_hazard;
    if (vecs[idx].id_ctrl.valid && vecs[idx].id_ctrl.periph &&
        !exp_h.id_stall && !exp_h.id_flush) begin
      tag_q.push_back(vecs[idx].id_ctrl.rd_addr);
    end
  endtask

  task automatic check_outputs(input int idx);
    vector_t v;
    v = vecs[idx];
    compare_field("hazard", idx, hazard, v.exp_hazard);
    compare_field("ex_fwd_a", idx, ex_fwd_a, v.exp_fwd_a);
    compare_field("ex_fwd_b", idx, ex_fwd_b, v.exp_fwd_b);
    compare_field("id_fwd_a", idx, id_fwd_a, v.exp_id_fwd_a);
    compare_field("id_fwd_b", idx, id_fwd_b, v.exp_id_fwd_b);
    compare_field("wb_ctrl.valid", idx, wb_ctrl.valid, v.exp_wb_valid);
    // rd of a bubble is don't care
    if (v.exp_wb_valid) begin
      compare_field("wb_ctrl.rd_addr", idx, wb_ctrl.rd_addr, v.exp_wb_rd);
    end
    compare_field("periph_req_valid", idx, periph_req_valid, v.exp_req_valid);
    // accesses reach MEM1 in program order, so requests carry their rd in that order
    if (v.exp_req_valid) begin
      if (tag_q.size() == 0) begin
        $display("ERROR: request expected at vector %0d with no periph access in flight", idx);
        errors++;
      end else begin
        compare_field("periph_req_tag", idx, periph_req_tag, tag_q.pop_front());
      end
    end
  endtask

  initial begin
    arst_n               = 1'b0;
    id_ctrl              = '0;
    periph_credit_return = 1'b0;
    periph_rsp_valid     = 1'b0;
    load_vectors();
    cycle_limit = num_vec + 20;
    if (num_vec == 0 && errors == 0) begin
      $display("ERROR: no vectors found in %s", VEC_FILE);
      errors++;
    end
    if (errors == 0) begin
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < num_vec; i++) begin
        @(posedge clk);
        apply_vector(i);
        // outputs have settled well before the next edge
        #(CLK_PERIOD - 10);
        check_outputs(i);
        track_periph_accept(i);
      end
    end
    finish_run();
  end

endmodule

// File: compile.f
+incdir+design
design/pipe_pkg.sv
design/hazard_unit.sv
design/stage_tracker.sv
design/periph_credit_port.sv
design/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/pipe_pkg.sv
      - design/hazard_unit.sv
      - design/stage_tracker.sv
      - design/periph_credit_port.sv
      - design/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_pipe_ctrl.sv

// File: test/pipe_ctrl_testdata.txt
# id_ctrl: valid rs1 rs2 rd result_src branch_taken periph trap, then credit_return rsp_valid
# expected: hazard ex_fwd_a ex_fwd_b id_fwd_a id_fwd_b wb_valid wb_rd periph_req_valid
1 01 02 03 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 03 0
1 00 00 05 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 05 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 05 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 05 05 06 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 07 1 0 0 0 0 0 000 1 1 0 0 1 05 0
1 00 00 08 0 0 0 0 0 0 000 0 0 0 0 1 05 0
1 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 05 0
1 07 08 09 0 0 0 0 0 0 000 0 0 0 0 1 06 0
1 00 07 0b 0 0 0 0 0 0 000 4 3 0 1 1 07 0
1 00 00 0c 1 0 0 0 0 0 000 0 0 0 0 1 08 0
1 00 00 0d 0 0 0 0 0 0 000 0 0 0 0 1 00 0
1 0c 0d 0e 0 0 0 0 0 0 000 0 0 0 0 1 09 0
0 00 00 00 0 0 0 0 0 0 000 2 1 0 0 1 0b 0
1 00 00 0f 1 0 0 0 0 0 000 0 0 0 0 1 0c 0
1 0f 00 10 0 0 0 0 0 0 180 0 0 0 0 1 0d 0
1 0f 00 10 0 0 0 0 0 0 000 0 0 0 0 1 0e 0
0 00 00 00 0 0 0 0 0 0 000 2 0 0 0 0 00 0
1 00 00 11 2 0 0 0 0 0 000 0 0 0 0 1 0f 0
1 00 00 12 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 11 13 0 0 0 0 0 0 180 0 0 0 0 1 10 0
1 00 11 13 0 0 0 0 0 0 180 0 0 0 0 0 00 0
1 00 11 13 0 0 0 0 0 0 000 0 0 0 1 1 11 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 12 0
1 00 00 14 2 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 00 0 1 0 0 0 0 000 0 0 0 0 0 00 0
1 14 00 15 0 0 0 0 0 0 018 0 0 0 0 1 13 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 14 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 00 0
1 00 00 16 0 0 0 1 0 0 000 0 0 0 0 0 00 0
1 00 00 17 0 0 0 0 0 0 010 0 0 0 0 0 00 0
1 00 00 18 0 0 0 0 0 0 018 0 0 0 0 0 00 0
1 00 00 19 0 0 0 0 0 0 01c 0 0 0 0 0 00 0
1 00 00 1a 0 0 0 0 0 0 01f 0 0 0 0 1 16 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 1b 1 0 1 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
1 00 00 1c 0 0 0 0 0 0 1e0 0 0 0 0 0 00 1
1 00 00 1c 0 0 0 0 0 0 1e0 0 0 0 0 0 00 0
1 00 00 1c 0 0 0 0 0 1 000 0 0 0 0 0 00 0
1 00 00 1d 1 0 1 0 0 0 000 0 0 0 0 0 00 0
1 00 00 1e 1 0 1 0 0 0 000 0 0 0 0 1 1b 0
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 0 00 1
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 1 1c 0
0 00 00 00 0 0 0 0 0 1 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 1 1d 0
0 00 00 00 0 0 0 0 1 0 1e0 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 0 00 1
0 00 00 00 0 0 0 0 0 0 1e0 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 1 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 0 00 0
0 00 00 00 0 0 0 0 0 0 000 0 0 0 0 1 1e 0
